/* verilog/mips_defs.svh */
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// ******************************
// core sizes

// data path and register width
`define MIPS_XLEN 32

// unified instruction and data RAM in words
`define MIPS_RAM_WORDS 256

// word address into the RAM
`define MIPS_RAM_AW 8

`endif

/* verilog/codes.sv */
`default_nettype none

package codes;

    typedef enum logic [1:0] {
        FETCH,
        EXEC1,
        EXEC2
    } state_t;

    // primary opcode field
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_t;

    // function field of the SPECIAL class
    typedef enum logic [5:0] {
        FUNC_JR   = 6'h08,
        FUNC_ADDU = 6'h21
    } func_t;

    // I-type reuses {rd, shamt, funct} as the 16 bit immediate
    typedef struct packed {
        opcode_t    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        func_t      funct;
    } instr_t;

    typedef struct packed {
        logic pc_wen;
        logic ir_wen;
        logic ram_wen;
        logic ram_rds;
        logic reg_wen;
        logic src_b_sel;   // 1 selects the immediate
        logic ram_a_sel;   // 1 selects the adder over the PC
        logic reg_wd_sel;  // 1 selects the adder over RAM data
        logic reg_a3_sel;  // 1 selects rd over rt
        logic pc_src_sel;  // 1 takes rs as the next PC
    } ctrl_t;

endpackage

`default_nettype wire

/* verilog/state_seq.sv */
`timescale 1ns/1ns
`default_nettype none

module state_seq (
    input  wire logic     clk_i,
    input  wire logic     arst_n_i,
    input  wire logic     run_i,
    output codes::state_t state_o,
    output logic          retire_o
);

    codes::state_t state_q;
    codes::state_t state_d;

    // an instruction in flight always completes and only FETCH waits for run
    always_comb begin
        case (state_q)
            codes::FETCH: state_d = run_i ? codes::EXEC1 : codes::FETCH;
            codes::EXEC1: state_d = codes::EXEC2;
            default:      state_d = codes::FETCH;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= codes::FETCH;
        end else begin
            state_q <= state_d;
        end
    end

    assign state_o  = state_q;
    assign retire_o = (state_q == codes::EXEC2);  // writes land at the end of EXEC2

    a_exec1_to_exec2: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (state_q == codes::EXEC1) |=> (state_q == codes::EXEC2)
    ) else $error("sequencer left EXEC1 for a state other than EXEC2");

endmodule

`default_nettype wire

/* verilog/control.sv */
`timescale 1ns/1ns
`default_nettype none

module control (
    input  wire codes::state_t  state_i,
    input  wire codes::opcode_t opcode_i,
    input  wire codes::func_t   function_i,
    output codes::ctrl_t        ctrl_o
);

    logic in_fetch;
    logic in_exec1;
    logic in_exec2;
    logic known_instr;

    assign in_fetch = (state_i == codes::FETCH);
    assign in_exec1 = (state_i == codes::EXEC1);
    assign in_exec2 = (state_i == codes::EXEC2);

    // ******************************
    // decode per instruction and state

    always_comb begin
        // every instruction is fetched, latched in EXEC1 and moves the PC in EXEC2
        ctrl_o         = '0;
        ctrl_o.pc_wen  = in_exec2;
        ctrl_o.ir_wen  = in_exec1;
        ctrl_o.ram_rds = in_fetch;
        known_instr    = 1'b1;

        case (opcode_i)
            codes::OP_SW: begin
                ctrl_o.ram_wen   = in_exec2;
                ctrl_o.src_b_sel = in_exec2;
                ctrl_o.ram_a_sel = in_exec2;
            end
            codes::OP_LW: begin
                ctrl_o.ram_rds   = in_fetch | in_exec1;  // second read fetches the data word
                ctrl_o.reg_wen   = in_exec2;
                ctrl_o.src_b_sel = in_exec1;
                ctrl_o.ram_a_sel = in_exec1;
            end
            codes::OP_ADDIU: begin
                ctrl_o.reg_wen    = in_exec2;
                ctrl_o.src_b_sel  = in_exec2;
                ctrl_o.reg_wd_sel = in_exec2;
            end
            codes::OP_SPECIAL: begin
                case (function_i)
                    codes::FUNC_JR: begin
                        ctrl_o.pc_src_sel = in_exec2;
                    end
                    codes::FUNC_ADDU: begin
                        ctrl_o.reg_wen    = in_exec2;
                        ctrl_o.reg_wd_sel = in_exec2;
                        ctrl_o.reg_a3_sel = in_exec2;
                    end
                    default: begin
                        known_instr = 1'b0;
                    end
                endcase
            end
            default: begin
                known_instr = 1'b0;
            end
        endcase
    end

    // ******************************
    // the sequencer only enters EXEC1 while running
    // so a bad word here is an undefined instruction executing

    always_comb begin
        if (in_exec1) begin
            a_known_instr: assert final (known_instr)
                else $error("undefined instruction opcode %0h function %0h",
                            opcode_i, function_i);
        end
    end

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mips_defs.svh"

module reg_file (
    input  wire logic                  clk_i,
    input  wire logic                  arst_n_i,
    input  wire logic [4:0]            a1_i,
    input  wire logic [4:0]            a2_i,
    input  wire logic [4:0]            a3_i,
    input  wire logic [`MIPS_XLEN-1:0] wd_i,
    input  wire logic                  wen_i,
    output logic [`MIPS_XLEN-1:0]      rd1_o,
    output logic [`MIPS_XLEN-1:0]      rd2_o
);

    logic [`MIPS_XLEN-1:0] regs_q [32];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wen_i && (a3_i != 5'd0)) begin  // register 0 is never written
            regs_q[a3_i] <= wd_i;
        end
    end

    // register 0 keeps its reset value so plain reads return zero
    assign rd1_o = regs_q[a1_i];
    assign rd2_o = regs_q[a2_i];

endmodule

`default_nettype wire

/* verilog/unified_ram.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mips_defs.svh"

module unified_ram (
    input  wire logic                    clk_i,
    input  wire logic [`MIPS_RAM_AW-1:0] addr_i,
    input  wire logic [`MIPS_XLEN-1:0]   wdata_i,
    input  wire logic                    wen_i,
    input  wire logic                    rds_i,
    input  wire logic                    load_we_i,
    input  wire logic [`MIPS_RAM_AW-1:0] load_addr_i,
    input  wire logic [`MIPS_XLEN-1:0]   load_data_i,
    input  wire logic                    run_i,
    output logic [`MIPS_XLEN-1:0]        rdata_o,
    input  wire logic [`MIPS_RAM_AW-1:0] dbg_addr_i,
    output logic [`MIPS_XLEN-1:0]        dbg_data_o
);

    logic [`MIPS_XLEN-1:0] mem [`MIPS_RAM_WORDS];

    always_ff @(posedge clk_i) begin
        if (load_we_i) begin
            mem[load_addr_i] <= load_data_i;  // program load wins over the core
        end else if (wen_i) begin
            mem[addr_i] <= wdata_i;
        end
    end

    // read data holds between strobes so LW still sees it in EXEC2
    always_ff @(posedge clk_i) begin
        if (rds_i) begin
            rdata_o <= mem[addr_i];
        end
    end

    assign dbg_data_o = mem[dbg_addr_i];

    // ******************************
    // the program is loaded only while the core is stopped

    a_load_idle: assert property (
        @(posedge clk_i) load_we_i |-> !run_i
    ) else $error("load write while the core is running");

endmodule

`default_nettype wire

/* verilog/datapath.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mips_defs.svh"

module datapath (
    input  wire logic                    clk_i,
    input  wire logic                    arst_n_i,
    input  wire codes::state_t           state_i,
    input  wire codes::ctrl_t            ctrl_i,
    input  wire logic [`MIPS_XLEN-1:0]   ram_rdata_i,
    output logic [`MIPS_RAM_AW-1:0]      ram_addr_o,
    output logic [`MIPS_XLEN-1:0]        ram_wdata_o,
    output codes::opcode_t               opcode_o,
    output codes::func_t                 function_o,
    output logic [4:0]                   rs_o,
    output logic [4:0]                   rt_o,
    output logic [4:0]                   reg_a3_o,
    output logic [`MIPS_XLEN-1:0]        reg_wd_o,
    input  wire logic [`MIPS_XLEN-1:0]   rd1_i,
    input  wire logic [`MIPS_XLEN-1:0]   rd2_i,
    output logic [`MIPS_XLEN-1:0]        pc_o
);

    logic [`MIPS_XLEN-1:0] pc_q;
    logic [`MIPS_XLEN-1:0] pc_next;
    codes::instr_t         ir_q;
    codes::instr_t         instr;
    logic [`MIPS_XLEN-1:0] imm_ext;
    logic [`MIPS_XLEN-1:0] src_b;
    logic [`MIPS_XLEN-1:0] sum;

    // ******************************
    // program counter and instruction register

    assign pc_next = ctrl_i.pc_src_sel ? rd1_i : pc_q + `MIPS_XLEN'(4);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= '0;
        end else if (ctrl_i.pc_wen) begin
            pc_q <= pc_next;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ctrl_i.ir_wen) begin
            ir_q <= codes::instr_t'(ram_rdata_i);
        end
    end

    // in EXEC1 the fetched word is still on the RAM output
    // and later states decode the latched copy
    assign instr = (state_i == codes::EXEC1) ? codes::instr_t'(ram_rdata_i) : ir_q;

    assign opcode_o   = instr.opcode;
    assign function_o = instr.funct;
    assign rs_o       = instr.rs;
    assign rt_o       = instr.rt;

    // ******************************
    // operands and the shared adder

    assign imm_ext = {{(`MIPS_XLEN-16){instr.rd[4]}}, instr.rd, instr.shamt, instr.funct};
    assign src_b   = ctrl_i.src_b_sel ? imm_ext : rd2_i;
    assign sum     = rd1_i + src_b;  // effective address or ALU result

    // byte addresses become word addresses for the RAM
    assign ram_addr_o  = ctrl_i.ram_a_sel ? sum[`MIPS_RAM_AW+1:2] : pc_q[`MIPS_RAM_AW+1:2];
    assign ram_wdata_o = rd2_i;

    // write-back picks the loaded word or the sum
    assign reg_wd_o = ctrl_i.reg_wd_sel ? sum : ram_rdata_i;
    assign reg_a3_o = ctrl_i.reg_a3_sel ? instr.rd : instr.rt;

    assign pc_o = pc_q;  // still the retiring PC throughout EXEC2

endmodule

`default_nettype wire

/* verilog/mips_core.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mips_defs.svh"

module mips_core (
    input  wire logic                    clk_i,
    input  wire logic                    arst_n_i,
    input  wire logic                    run_i,
    input  wire logic                    load_we_i,
    input  wire logic [`MIPS_RAM_AW-1:0] load_addr_i,
    input  wire logic [`MIPS_XLEN-1:0]   load_data_i,
    input  wire logic [`MIPS_RAM_AW-1:0] dbg_addr_i,
    output logic [`MIPS_XLEN-1:0]        dbg_data_o,
    output logic                         retire_o,
    output logic [`MIPS_XLEN-1:0]        retire_pc_o
);

    codes::state_t           state;
    codes::ctrl_t            ctrl;
    codes::opcode_t          opcode;
    codes::func_t            funct;
    logic [4:0]              rs;
    logic [4:0]              rt;
    logic [4:0]              reg_a3;
    logic [`MIPS_XLEN-1:0]   reg_wd;
    logic [`MIPS_XLEN-1:0]   rd1;
    logic [`MIPS_XLEN-1:0]   rd2;
    logic [`MIPS_RAM_AW-1:0] ram_addr;
    logic [`MIPS_XLEN-1:0]   ram_wdata;
    logic [`MIPS_XLEN-1:0]   ram_rdata;

    state_seq u_state_seq (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .run_i    (run_i),
        .state_o  (state),
        .retire_o (retire_o)
    );

    control u_control (
        .state_i    (state),
        .opcode_i   (opcode),
        .function_i (funct),
        .ctrl_o     (ctrl)
    );

    datapath u_datapath (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .state_i     (state),
        .ctrl_i      (ctrl),
        .ram_rdata_i (ram_rdata),
        .ram_addr_o  (ram_addr),
        .ram_wdata_o (ram_wdata),
        .opcode_o    (opcode),
        .function_o  (funct),
        .rs_o        (rs),
        .rt_o        (rt),
        .reg_a3_o    (reg_a3),
        .reg_wd_o    (reg_wd),
        .rd1_i       (rd1),
        .rd2_i       (rd2),
        .pc_o        (retire_pc_o)
    );

    reg_file u_reg_file (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .a1_i     (rs),
        .a2_i     (rt),
        .a3_i     (reg_a3),
        .wd_i     (reg_wd),
        .wen_i    (ctrl.reg_wen),
        .rd1_o    (rd1),
        .rd2_o    (rd2)
    );

    unified_ram u_unified_ram (
        .clk_i       (clk_i),
        .addr_i      (ram_addr),
        .wdata_i     (ram_wdata),
        .wen_i       (ctrl.ram_wen),
        .rds_i       (ctrl.ram_rds),
        .load_we_i   (load_we_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .run_i       (run_i),
        .rdata_o     (ram_rdata),
        .dbg_addr_i  (dbg_addr_i),
        .dbg_data_o  (dbg_data_o)
    );

endmodule

`default_nettype wire

/* dv/tb_mips_core.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mips_defs.svh"

module tb_mips_core;

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 5;
    localparam int PROG_WORDS     = 96;
    localparam int DATA_BASE      = 192;  // first word of the data region
    localparam int DATA_WORDS     = 64;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + `MIPS_RAM_WORDS + 3 * PROG_WORDS
                                    + DATA_WORDS + 100;
    localparam logic [31:0] SEED  = 32'hf72b_50ba;

    // MIPS encodings of the supported subset
    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_LW      = 6'h23;
    localparam logic [5:0] OPC_SW      = 6'h2b;
    localparam logic [5:0] FN_JR       = 6'h08;
    localparam logic [5:0] FN_ADDU     = 6'h21;

    logic                    clk;
    logic                    arst_n;
    logic                    run;
    logic                    load_we;
    logic [`MIPS_RAM_AW-1:0] load_addr;
    logic [`MIPS_XLEN-1:0]   load_data;
    logic [`MIPS_RAM_AW-1:0] dbg_addr;
    logic [`MIPS_XLEN-1:0]   dbg_data;
    logic                    retire;
    logic [`MIPS_XLEN-1:0]   retire_pc;

    logic [31:0] image [`MIPS_RAM_WORDS];       // RAM contents as loaded
    logic [31:0] model_mem [`MIPS_RAM_WORDS];
    logic [31:0] model_regs [32];
    logic [31:0] exp_pc_q [$];
    int          prog_len;
    int          cycle_count       = 0;
    int          last_retire_cycle = 0;
    int          retire_count      = 0;

    mips_core DUT (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .run_i       (run),
        .load_we_i   (load_we),
        .load_addr_i (load_addr),
        .load_data_i (load_data),
        .dbg_addr_i  (dbg_addr),
        .dbg_data_o  (dbg_data),
        .retire_o    (retire),
        .retire_pc_o (retire_pc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ******************************
    // failure reporting

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t ns: %s = %h, expected %h",
                                $time, name, got, exp));
        end
    endtask

    // ******************************
    // random program generation

    function automatic logic [4:0] pick_data_reg();
        int r;
        r = int'($urandom_range(0, 13));
        return (r == 0) ? 5'd0 : 5'(r + 2);  // r0 or r3..r15
    endfunction

    // r1 holds 0x300 and r2 holds 0x400 so every form lands in the data region
    task automatic pick_mem_operand(output logic [4:0] base, output logic [15:0] off);
        int word;
        word = int'($urandom_range(0, DATA_WORDS - 1));
        case ($urandom_range(0, 2))
            0: begin
                base = 5'd0;
                off  = 16'((DATA_BASE + word) * 4);
            end
            1: begin
                base = 5'd1;
                off  = 16'(word * 4);
            end
            default: begin
                base = 5'd2;
                off  = 16'((word - DATA_WORDS) * 4);  // negative offset
            end
        endcase
    endtask

    task automatic gen_simple(output logic [31:0] w);
        logic [4:0]  base;
        logic [15:0] off;
        pick_mem_operand(base, off);
        case ($urandom_range(0, 3))
            0:       w = {OPC_ADDIU, pick_data_reg(), pick_data_reg(), 16'($urandom)};
            1:       w = {OPC_SPECIAL, pick_data_reg(), pick_data_reg(), pick_data_reg(),
                          5'd0, FN_ADDU};
            2:       w = {OPC_SW, base, pick_data_reg(), off};
            default: w = {OPC_LW, base, pick_data_reg(), off};
        endcase
    endtask

    task automatic build_program();
        int          idx;
        int          kind;
        int          skip;
        logic [4:0]  base;
        logic [4:0]  src;
        logic [4:0]  dst;
        logic [15:0] off;
        logic [31:0] w;
        for (int a = 0; a < `MIPS_RAM_WORDS; a++) begin
            image[a] = {8'(a), ~8'(a), 8'(a) ^ 8'h5a, 8'(a * 7)};
        end
        image[0] = {OPC_ADDIU, 5'd0, 5'd1, 16'h0300};
        image[1] = {OPC_ADDIU, 5'd0, 5'd2, 16'h0400};
        image[2] = {OPC_ADDIU, 5'd0, 5'd0, 16'h7fff};  // must leave r0 at zero
        image[3] = {OPC_SW, 5'd1, 5'd0, 16'h0000};
        idx = 4;
        while (idx < PROG_WORDS - 8) begin
            kind = int'($urandom_range(0, 9));
            if (kind < 7) begin
                gen_simple(w);
                image[idx] = w;
                idx++;
            end else if (kind < 9) begin
                // store, load back the same word, store the loaded copy elsewhere
                pick_mem_operand(base, off);
                src = pick_data_reg();
                dst = pick_data_reg();
                image[idx]     = {OPC_SW, base, src, off};
                image[idx + 1] = {OPC_LW, base, dst, off};
                pick_mem_operand(base, off);
                image[idx + 2] = {OPC_SW, base, dst, off};
                idx += 3;
            end else begin
                skip = int'($urandom_range(1, 3));
                image[idx]     = {OPC_ADDIU, 5'd0, 5'd31, 16'((idx + 2 + skip) * 4)};
                image[idx + 1] = {OPC_SPECIAL, 5'd31, 5'd0, 5'd0, 5'd0, FN_JR};
                for (int k = 0; k < skip; k++) begin
                    gen_simple(w);
                    image[idx + 2 + k] = w;  // jumped over, never retires
                end
                idx += 2 + skip;
            end
        end
        prog_len = idx;
    endtask

    // ******************************
    // instruction-set reference

    function automatic void execute_program();
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] imm;
        logic [31:0] ea;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        int          steps;
        pc    = 32'd0;
        steps = 0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = 32'd0;
        end
        for (int a = 0; a < `MIPS_RAM_WORDS; a++) begin
            model_mem[a] = image[a];
        end
        while (pc != 32'(prog_len * 4) && steps < 4 * PROG_WORDS) begin
            w   = model_mem[pc[9:2]];
            rs  = w[25:21];
            rt  = w[20:16];
            rd  = w[15:11];
            imm = {{16{w[15]}}, w[15:0]};
            ea  = model_regs[rs] + imm;
            exp_pc_q.push_back(pc);
            pc = pc + 32'd4;
            case (w[31:26])
                OPC_ADDIU: if (rt != 5'd0) model_regs[rt] = ea;
                OPC_LW:    if (rt != 5'd0) model_regs[rt] = model_mem[ea[9:2]];
                OPC_SW:    model_mem[ea[9:2]] = model_regs[rt];
                OPC_SPECIAL: begin
                    if (w[5:0] == FN_JR) begin
                        pc = model_regs[rs];
                    end else if (rd != 5'd0) begin
                        model_regs[rd] = model_regs[rs] + model_regs[rt];
                    end
                end
                default: ;
            endcase
            steps++;
        end
    endfunction

    task automatic load_image();
        for (int a = 0; a < `MIPS_RAM_WORDS; a++) begin
            load_we   = 1'b1;
            load_addr = 8'(a);
            load_data = image[a];
            @(negedge clk);
        end
        load_we = 1'b0;
    endtask

    // ******************************
    // retire checks sample on the rising edge

    always @(posedge clk) begin
        if (arst_n) begin
            cycle_count++;
            if (retire !== 1'b0) begin
                if (exp_pc_q.size() == 0) begin
                    abort_run($sformatf("retire pulse at %0t ns with no instruction left",
                                        $time));
                end else begin
                    check_value("retire_pc_o", retire_pc, exp_pc_q.pop_front());
                    if (retire_count > 0) begin
                        check_value("retire_o spacing",
                                    32'(cycle_count - last_retire_cycle), 32'd3);
                    end
                    last_retire_cycle = cycle_count;
                    retire_count++;
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        abort_run($sformatf("watchdog expired after %0d cycles", TIMEOUT_CYCLES));
    end

    initial begin
        void'($urandom(SEED));
        arst_n    = 1'b0;
        run       = 1'b0;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        dbg_addr  = '0;
        build_program();
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        load_image();  // no instruction may retire while the program loads
        execute_program();
        $display("program of %0d words, %0d instructions to retire",
                 prog_len, exp_pc_q.size());
        run = 1'b1;
        while (exp_pc_q.size() != 0) begin
            @(negedge clk);
        end
        run = 1'b0;  // core parks in FETCH after the last retire
        repeat (4) @(negedge clk);

        for (int a = DATA_BASE; a < DATA_BASE + DATA_WORDS; a++) begin
            dbg_addr = 8'(a);
            @(posedge clk);
            check_value($sformatf("dbg_data_o[word %0d]", a), dbg_data, model_mem[a]);
            @(negedge clk);
        end
        $display("%0d instructions retired", retire_count);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+verilog
verilog/codes.sv
verilog/state_seq.sv
verilog/control.sv
verilog/reg_file.sv
verilog/unified_ram.sv
verilog/datapath.sv
verilog/mips_core.sv
dv/tb_mips_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the MIPS core testbench with Verilator and runs it

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=tb_mips_core
LOG_FILE=sim.log

verilator --binary --timing --assert \
    -f compile.f \
    --top-module tb_mips_core \
    --Mdir "${BUILD_DIR}" \
    -o "${SIM_BIN}"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./${BUILD_DIR}/${SIM_BIN}" > "${LOG_FILE}" 2>&1
sim_status=$?
cat "${LOG_FILE}"
if [ ${sim_status} -ne 0 ]; then
    echo "simulation exited with status ${sim_status}"
    exit 1
fi

if grep -qF "*** TEST PASSED ***" "${LOG_FILE}"; then
    exit 0
fi
echo "pass message not found in ${LOG_FILE}"
exit 1
